// ==== cpu16.f ====
+incdir+rtl
+incdir+tests
rtl/isaPkg.sv
rtl/ctrlPkg.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/cpu.sv
tests/cpuTb.sv

// ==== rtl/cpu.sv ====
`timescale 1ns/1ns
`include "cpu_params.svh"

module cpu
  import ctrlPkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  output logic [`DATA_WIDTH-1:0] instrAddr,
  input  logic [`DATA_WIDTH-1:0] instr,
  output logic                   cyc,
  output logic                   stb,
  output logic                   we,
  output logic [`ADDR_WIDTH-1:0] adr,
  output logic [`DATA_WIDTH-1:0] datOut,
  input  logic [`DATA_WIDTH-1:0] datIn,
  input  logic                   ack,
  output logic                   hlt,
  output logic [`DATA_WIDTH-1:0] pc
);

  // Pipeline control
  logic busStall, hazard, interlock, flush, branch, bubbleId, haltBlock, hltHeld;
  logic [`DATA_WIDTH-1:0] branchAddr, pcNextIf;

  // IF/ID
  logic [`DATA_WIDTH-1:0] instrIfId, pcNextIfId;
  logic validIfId;

  // Decode outputs and ID/EX
  logic [`DATA_WIDTH-1:0] p0Id, p1Id, immId;
  logic [3:0] shamtId, regAddrId;
  aluOpT aluOpId;
  branchCondT condId;
  logic aluSrcId, regWeId, memReId, memWeId, memToRegId, isBranchId, flagEnId, haltId;
  logic [`DATA_WIDTH-1:0] p0IdEx, p1IdEx, immIdEx, pcNextIdEx;
  logic [3:0] shamtIdEx, regAddrIdEx;
  aluOpT aluOpIdEx;
  branchCondT condIdEx;
  logic aluSrcIdEx, regWeIdEx, memReIdEx, memWeIdEx, memToRegIdEx;
  logic isBranchIdEx, flagEnIdEx, haltIdEx;

  // Execute outputs and EX/MEM
  logic [`DATA_WIDTH-1:0] aluResultEx, branchTargetEx;
  logic zrEx, neEx, ovEx;
  logic [`DATA_WIDTH-1:0] aluResultExMem, branchTargetExMem, storeDataExMem;
  logic [3:0] regAddrExMem;
  branchCondT condExMem;
  logic zrExMem, neExMem, ovExMem;
  logic regWeExMem, memReExMem, memWeExMem, memToRegExMem;
  logic isBranchExMem, flagEnExMem, haltExMem;

  // Memory outputs, MEM/WB and writeback
  logic [`DATA_WIDTH-1:0] memDataMem, memDataMemWb, aluResultMemWb, dst;
  logic [3:0] regAddrMemWb;
  logic memToRegMemWb, regWeMemWb, haltMemWb;

  assign instrAddr = pc;
  assign flush     = branch;
  assign interlock = validIfId & hazard;
  // Nothing younger than a halt in flight may proceed
  assign haltBlock = haltIdEx | haltExMem | haltMemWb | hltHeld;
  assign bubbleId  = interlock | ~validIfId | haltBlock;

  fetchStage fetch (
    .clk(clk), .reset(reset), .stall(busStall | interlock), .branch(branch),
    .branchAddr(branchAddr), .halted((haltId & validIfId) | haltBlock),
    .pc(pc), .pcNext(pcNextIf)
  );

  //****************************************
  // IF/ID
  //****************************************
  always_ff @(posedge clk)
  begin
    if (reset || flush)
      validIfId <= 1'b0;
    else if (!busStall && !interlock)
    begin
      validIfId  <= 1'b1;
      instrIfId  <= instr;
      pcNextIfId <= pcNextIf;
    end
  end

  decodeStage decode (
    .clk(clk), .reset(reset), .instr(instrIfId),
    .exDst(regAddrIdEx), .exWe(regWeIdEx), .memDst(regAddrExMem), .memStageWe(regWeExMem),
    .dstAddr(regAddrMemWb), .dst(dst), .dstWe(regWeMemWb),
    .p0(p0Id), .p1(p1Id), .imm(immId), .shamt(shamtId), .aluOp(aluOpId), .aluSrc(aluSrcId),
    .regAddr(regAddrId), .regWe(regWeId), .memRe(memReId), .memWe(memWeId),
    .memToReg(memToRegId), .isBranch(isBranchId), .cond(condId), .flagEn(flagEnId),
    .halt(haltId), .hazard(hazard)
  );

  //****************************************
  // ID/EX
  //****************************************
  always_ff @(posedge clk)
  begin
    if (reset || flush || (bubbleId && !busStall))
    begin
      regWeIdEx    <= 1'b0;
      memReIdEx    <= 1'b0;
      memWeIdEx    <= 1'b0;
      isBranchIdEx <= 1'b0;
      flagEnIdEx   <= 1'b0;
      haltIdEx     <= 1'b0;
    end
    else if (!busStall)
    begin
      regWeIdEx    <= regWeId;
      memReIdEx    <= memReId;
      memWeIdEx    <= memWeId;
      isBranchIdEx <= isBranchId;
      flagEnIdEx   <= flagEnId;
      haltIdEx     <= haltId;
      p0IdEx       <= p0Id;
      p1IdEx       <= p1Id;
      immIdEx      <= immId;
      pcNextIdEx   <= pcNextIfId;
      shamtIdEx    <= shamtId;
      regAddrIdEx  <= regAddrId;
      aluOpIdEx    <= aluOpId;
      condIdEx     <= condId;
      aluSrcIdEx   <= aluSrcId;
      memToRegIdEx <= memToRegId;
    end
  end

  executeStage execute (
    .p0(p0IdEx), .p1(p1IdEx), .imm(immIdEx), .shamt(shamtIdEx), .aluOp(aluOpIdEx),
    .aluSrc(aluSrcIdEx), .pcNext(pcNextIdEx), .aluResult(aluResultEx),
    .branchTarget(branchTargetEx), .zr(zrEx), .ne(neEx), .ov(ovEx)
  );

  //****************************************
  // EX/MEM
  //****************************************
  always_ff @(posedge clk)
  begin
    if (reset || flush)
    begin
      regWeExMem    <= 1'b0;
      memReExMem    <= 1'b0;
      memWeExMem    <= 1'b0;
      isBranchExMem <= 1'b0;
      flagEnExMem   <= 1'b0;
      haltExMem     <= 1'b0;
    end
    else if (!busStall)
    begin
      regWeExMem        <= regWeIdEx;
      memReExMem        <= memReIdEx;
      memWeExMem        <= memWeIdEx;
      isBranchExMem     <= isBranchIdEx;
      flagEnExMem       <= flagEnIdEx;
      haltExMem         <= haltIdEx;
      aluResultExMem    <= aluResultEx;
      branchTargetExMem <= branchTargetEx;
      storeDataExMem    <= p1IdEx;
      regAddrExMem      <= regAddrIdEx;
      condExMem         <= condIdEx;
      memToRegExMem     <= memToRegIdEx;
      zrExMem           <= zrEx;
      neExMem           <= neEx;
      ovExMem           <= ovEx;
    end
  end

  memoryStage memory (
    .clk(clk), .reset(reset), .memRe(memReExMem), .memWe(memWeExMem),
    .addr(aluResultExMem), .wrData(storeDataExMem), .isBranch(isBranchExMem),
    .cond(condExMem), .branchTarget(branchTargetExMem),
    .zr(zrExMem), .ne(neExMem), .ov(ovExMem), .flagEn(flagEnExMem),
    .cyc(cyc), .stb(stb), .we(we), .adr(adr), .datOut(datOut), .datIn(datIn), .ack(ack),
    .memData(memDataMem), .branch(branch), .branchAddr(branchAddr), .stall(busStall)
  );

  //****************************************
  // MEM/WB and writeback select
  //****************************************
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      regWeMemWb <= 1'b0;
      haltMemWb  <= 1'b0;
    end
    else if (!busStall)
    begin
      regWeMemWb     <= regWeExMem;
      haltMemWb      <= haltExMem;
      memDataMemWb   <= memDataMem;
      aluResultMemWb <= aluResultExMem;
      regAddrMemWb   <= regAddrExMem;
      memToRegMemWb  <= memToRegExMem;
    end
  end

  assign dst = memToRegMemWb ? memDataMemWb : aluResultMemWb;

  // Sticky once the halt retires
  always_ff @(posedge clk)
  begin
    if (reset)
      hltHeld <= 1'b0;
    else if (haltMemWb)
      hltHeld <= 1'b1;
  end

  assign hlt = hltHeld | haltMemWb;

endmodule

// ==== rtl/cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Width of data words, registers and the PC
`define DATA_WIDTH 16

// Register file depth
`define REG_COUNT 16

`define RESET_PC 16'h0000

// Wishbone word address
`define ADDR_WIDTH 16

`endif

// ==== rtl/ctrlPkg.sv ====
package ctrlPkg;

  // ALU operations, first seven line up with the ALU opcodes
  typedef enum logic [2:0] {
    ALU_ADD  = 3'd0,
    ALU_SUB  = 3'd1,
    ALU_AND  = 3'd2,
    ALU_OR   = 3'd3,
    ALU_XOR  = 3'd4,
    ALU_SLL  = 3'd5,
    ALU_SRL  = 3'd6,
    ALU_PASS = 3'd7
  } aluOpT;

  // Conditions tested against the flags register in MEM
  typedef enum logic [3:0] {
    EQ = 4'h0,
    NE = 4'h1,
    LT = 4'h2,
    GE = 4'h3,
    OV = 4'h4,
    AL = 4'h5
  } branchCondT;

endpackage

// ==== rtl/decodeStage.sv ====
`timescale 1ns/1ns
`include "cpu_params.svh"

module decodeStage
  import isaPkg::*, ctrlPkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  instrT                  instr,
  input  logic [3:0]             exDst,
  input  logic                   exWe,
  input  logic [3:0]             memDst,
  input  logic                   memStageWe,
  input  logic [3:0]             dstAddr,
  input  logic [`DATA_WIDTH-1:0] dst,
  input  logic                   dstWe,
  output logic [`DATA_WIDTH-1:0] p0,
  output logic [`DATA_WIDTH-1:0] p1,
  output logic [`DATA_WIDTH-1:0] imm,
  output logic [3:0]             shamt,
  output aluOpT                  aluOp,
  output logic                   aluSrc,
  output logic [3:0]             regAddr,
  output logic                   regWe, memRe, memWe, memToReg, isBranch,
  output branchCondT             cond,
  output logic                   flagEn, halt, hazard
);

  logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];
  logic [3:0] rs;
  logic [3:0] p1Addr;
  logic useRs, useP1;
  logic rsHit, p1Hit;
  logic isMemOp;

  assign rs = instr.regForm.rs;
  // Stores read their data register through the second port
  assign p1Addr = (instr.regForm.opcode == SW) ? instr.regForm.rd : instr.regForm.rt;
  assign isMemOp = (instr.regForm.opcode == LW) || (instr.regForm.opcode == SW);

  // Known zero state after reset
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int k = 0; k < `REG_COUNT; k++)
        regs[k] <= '0;
    end
    else if (dstWe)
      regs[dstAddr] <= dst;
  end

  // Writeback value bypasses the array on a same-cycle read
  assign p0 = (dstWe && dstAddr == rs) ? dst : regs[rs];
  assign p1 = (dstWe && dstAddr == p1Addr) ? dst : regs[p1Addr];

  assign regAddr = instr.regForm.rd;
  assign shamt   = instr.regForm.rt;
  assign cond    = branchCondT'(instr.immForm.rd);

  // Memory offset is an unsigned nibble, LLI and BR take a signed byte
  assign imm = isMemOp ? {{(`DATA_WIDTH-4){1'b0}}, instr.regForm.rt}
                       : {{(`DATA_WIDTH-8){instr.immForm.imm8[7]}}, instr.immForm.imm8};

  always_comb
  begin
    aluOp    = ALU_ADD;
    aluSrc   = 1'b0;
    regWe    = 1'b0;
    memRe    = 1'b0;
    memWe    = 1'b0;
    memToReg = 1'b0;
    isBranch = 1'b0;
    flagEn   = 1'b0;
    halt     = 1'b0;
    useRs    = 1'b0;
    useP1    = 1'b0;
    case (instr.regForm.opcode)
      ADD, SUB, AND, OR, XOR, SLL, SRL:
      begin
        aluOp  = aluOpT'(instr.regForm.opcode[2:0]);
        regWe  = 1'b1;
        flagEn = 1'b1;
        useRs  = 1'b1;
        // Shifts take rt as an amount, not a register
        useP1  = (instr.regForm.opcode != SLL) && (instr.regForm.opcode != SRL);
      end
      LLI:
      begin
        aluOp  = ALU_PASS;
        aluSrc = 1'b1;
        regWe  = 1'b1;
      end
      LW:
      begin
        aluSrc   = 1'b1;
        regWe    = 1'b1;
        memRe    = 1'b1;
        memToReg = 1'b1;
        useRs    = 1'b1;
      end
      SW:
      begin
        aluSrc = 1'b1;
        memWe  = 1'b1;
        useRs  = 1'b1;
        useP1  = 1'b1;
      end
      BR:  isBranch = 1'b1;
      HLT: halt = 1'b1;
      default: ;
    endcase
  end

  // Interlock against results still in EX or MEM
  assign rsHit  = (exWe && exDst == rs) || (memStageWe && memDst == rs);
  assign p1Hit  = (exWe && exDst == p1Addr) || (memStageWe && memDst == p1Addr);
  assign hazard = (useRs && rsHit) || (useP1 && p1Hit);

endmodule

// ==== rtl/executeStage.sv ====
`timescale 1ns/1ns
`include "cpu_params.svh"

module executeStage
  import ctrlPkg::*;
(
  input  logic [`DATA_WIDTH-1:0] p0,
  input  logic [`DATA_WIDTH-1:0] p1,
  input  logic [`DATA_WIDTH-1:0] imm,
  input  logic [3:0]             shamt,
  input  aluOpT                  aluOp,
  input  logic                   aluSrc,
  input  logic [`DATA_WIDTH-1:0] pcNext,
  output logic [`DATA_WIDTH-1:0] aluResult,
  output logic [`DATA_WIDTH-1:0] branchTarget,
  output logic                   zr,
  output logic                   ne,
  output logic                   ov
);

  localparam int Msb = `DATA_WIDTH - 1;

  logic [`DATA_WIDTH-1:0] opB;

  assign opB = aluSrc ? imm : p1;

  always_comb
  begin
    ov = 1'b0;
    case (aluOp)
      ALU_ADD:
      begin
        aluResult = p0 + opB;
        ov = (p0[Msb] == opB[Msb]) && (aluResult[Msb] != p0[Msb]);
      end
      ALU_SUB:
      begin
        aluResult = p0 - opB;
        ov = (p0[Msb] != opB[Msb]) && (aluResult[Msb] != p0[Msb]);
      end
      ALU_AND: aluResult = p0 & opB;
      ALU_OR:  aluResult = p0 | opB;
      ALU_XOR: aluResult = p0 ^ opB;
      ALU_SLL: aluResult = p0 << shamt;
      ALU_SRL: aluResult = p0 >> shamt;
      // LLI passes the extended constant
      default: aluResult = opB;
    endcase
  end

  assign zr = (aluResult == '0);
  assign ne = aluResult[Msb];

  // Relative to the instruction after the branch
  assign branchTarget = pcNext + imm;

endmodule

// ==== rtl/fetchStage.sv ====
`timescale 1ns/1ns
`include "cpu_params.svh"

module fetchStage (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   stall,
  input  logic                   branch,
  input  logic [`DATA_WIDTH-1:0] branchAddr,
  input  logic                   halted,
  output logic [`DATA_WIDTH-1:0] pc,
  output logic [`DATA_WIDTH-1:0] pcNext
);

  // Sequential successor, also carried down the pipe for branch targets
  assign pcNext = pc + 1'b1;

  always_ff @(posedge clk)
  begin
    if (reset)
      pc <= `RESET_PC;
    // Taken branch is older than anything holding the PC
    else if (branch)
      pc <= branchAddr;
    else if (!stall && !halted)
      pc <= pcNext;
  end

endmodule

// ==== rtl/isaPkg.sv ====
package isaPkg;

  // Major opcode in the top nibble of every instruction
  typedef enum logic [3:0] {
    ADD = 4'h0,
    SUB = 4'h1,
    AND = 4'h2,
    OR  = 4'h3,
    XOR = 4'h4,
    SLL = 4'h5,
    SRL = 4'h6,
    LLI = 4'h7,
    LW  = 4'h8,
    SW  = 4'h9,
    BR  = 4'hA,
    HLT = 4'hB
  } opcodeT;

  // One instruction word read two ways
  typedef union packed {
    // Register form where rt also serves as shift amount or memory offset
    struct packed {
      opcodeT     opcode;
      logic [3:0] rd;
      logic [3:0] rs;
      logic [3:0] rt;
    } regForm;
    // Immediate form for LLI and BR, BR keeps its condition in rd
    struct packed {
      opcodeT     opcode;
      logic [3:0] rd;
      logic [7:0] imm8;
    } immForm;
  } instrT;

endpackage

// ==== rtl/memoryStage.sv ====
`timescale 1ns/1ns
`include "cpu_params.svh"

module memoryStage
  import ctrlPkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   memRe,
  input  logic                   memWe,
  input  logic [`DATA_WIDTH-1:0] addr,
  input  logic [`DATA_WIDTH-1:0] wrData,
  input  logic                   isBranch,
  input  branchCondT             cond,
  input  logic [`DATA_WIDTH-1:0] branchTarget,
  input  logic                   zr,
  input  logic                   ne,
  input  logic                   ov,
  input  logic                   flagEn,
  output logic                   cyc,
  output logic                   stb,
  output logic                   we,
  output logic [`ADDR_WIDTH-1:0] adr,
  output logic [`DATA_WIDTH-1:0] datOut,
  input  logic [`DATA_WIDTH-1:0] datIn,
  input  logic                   ack,
  output logic [`DATA_WIDTH-1:0] memData,
  output logic                   branch,
  output logic [`DATA_WIDTH-1:0] branchAddr,
  output logic                   stall
);

  logic access;
  logic zrFlag, neFlag, ovFlag;
  logic condMet;

  //****************************************
  // Wishbone classic master
  //****************************************
  assign access = memRe | memWe;

  // Request held until ack, EX/MEM moves on at that same edge
  assign cyc    = access;
  assign stb    = access;
  assign we     = memWe;
  assign adr    = addr[`ADDR_WIDTH-1:0];
  assign datOut = wrData;
  assign stall  = access & ~ack;

  // Captured into MEM/WB on the ack edge
  assign memData = datIn;

  //****************************************
  // Flags and branch decision
  //****************************************
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      zrFlag <= 1'b0;
      neFlag <= 1'b0;
      ovFlag <= 1'b0;
    end
    else if (flagEn)
    begin
      zrFlag <= zr;
      neFlag <= ne;
      ovFlag <= ov;
    end
  end

  always_comb
  begin
    case (cond)
      EQ:      condMet = zrFlag;
      NE:      condMet = ~zrFlag;
      LT:      condMet = neFlag;
      GE:      condMet = ~neFlag;
      OV:      condMet = ovFlag;
      AL:      condMet = 1'b1;
      default: condMet = 1'b0;
    endcase
  end

  assign branch     = isBranch & condMet;
  assign branchAddr = branchTarget;

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the cpu16 testbench with Verilator, run it and judge the run by its output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f cpu16.f --top-module cpuTb -o cpuTbSim \
  && simOut="$(./obj_dir/cpuTbSim)" \
  && printf '%s\n' "$simOut" \
  && grep -q "^TESTS PASSED$" <<< "$simOut" \
  && echo "Simulation run passed" \
  || { echo "Simulation run failed"; exit 1; }

// ==== tests/refModel.svh ====
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// Program image seen by the instruction port and by the model
logic [15:0] prog [256];
int progLen;

// Expected results of the current program
logic [15:0] expAddr [$];
logic [15:0] expData [$];
logic [15:0] refHaltPc;
int refInstrCount;
int refMemOps;

// Power-up contents of data memory
function automatic logic [15:0] fillWord(input logic [15:0] a);
  return {a[7:0], a[15:8]} ^ 16'hC3A5;
endfunction

//****************************************
// Program builder
//****************************************
function automatic void clearProgram();
  progLen = 0;
  for (int i = 0; i < 256; i++)
    prog[i] = {HLT, 12'h000};
endfunction

function automatic void emitReg(input opcodeT op, input int rd, input int rs, input int rt);
  instrT w;
  w.regForm.opcode = op;
  w.regForm.rd = rd[3:0];
  w.regForm.rs = rs[3:0];
  w.regForm.rt = rt[3:0];
  prog[progLen] = w;
  progLen++;
endfunction

function automatic void emitImm(input opcodeT op, input int rd, input logic [7:0] imm8);
  instrT w;
  w.immForm.opcode = op;
  w.immForm.rd = rd[3:0];
  w.immForm.imm8 = imm8;
  prog[progLen] = w;
  progLen++;
endfunction

//****************************************
// Instruction-level model
//****************************************
function automatic void runReference();
  logic [15:0] regs [16];
  logic [15:0] mem [logic [15:0]];
  logic [15:0] pcRef, nextPc, a, b, r, ea, simm;
  logic [16:0] wide;
  logic zf, nf, vf, taken, done;
  instrT w;
  opcodeT op;
  int steps;
  for (int i = 0; i < 16; i++)
    regs[i] = '0;
  zf = 1'b0;
  nf = 1'b0;
  vf = 1'b0;
  done = 1'b0;
  steps = 0;
  pcRef = `RESET_PC;
  refInstrCount = 0;
  refMemOps = 0;
  expAddr.delete();
  expData.delete();
  while (!done && steps < 4000)
  begin
    w = prog[pcRef[7:0]];
    op = w.regForm.opcode;
    a = regs[w.regForm.rs];
    b = regs[w.regForm.rt];
    simm = {{8{w.immForm.imm8[7]}}, w.immForm.imm8};
    ea = a + {12'h000, w.regForm.rt};
    nextPc = pcRef + 16'd1;
    refInstrCount++;
    steps++;
    case (op)
      ADD, SUB, AND, OR, XOR, SLL, SRL:
      begin
        vf = 1'b0;
        case (op)
          ADD:
          begin
            wide = {a[15], a} + {b[15], b};
            r = wide[15:0];
            vf = wide[16] ^ wide[15];
          end
          SUB:
          begin
            wide = {a[15], a} - {b[15], b};
            r = wide[15:0];
            vf = wide[16] ^ wide[15];
          end
          AND: r = a & b;
          OR: r = a | b;
          XOR: r = a ^ b;
          SLL: r = a << w.regForm.rt;
          default: r = a >> w.regForm.rt;
        endcase
        regs[w.regForm.rd] = r;
        zf = (r == 16'h0000);
        nf = r[15];
      end
      LLI: regs[w.immForm.rd] = simm;
      LW:
      begin
        regs[w.regForm.rd] = mem.exists(ea) ? mem[ea] : fillWord(ea);
        refMemOps++;
      end
      SW:
      begin
        mem[ea] = regs[w.regForm.rd];
        expAddr.push_back(ea);
        expData.push_back(regs[w.regForm.rd]);
        refMemOps++;
      end
      BR:
      begin
        case (branchCondT'(w.immForm.rd))
          EQ: taken = zf;
          NE: taken = !zf;
          LT: taken = nf;
          GE: taken = !nf;
          OV: taken = vf;
          AL: taken = 1'b1;
          default: taken = 1'b0;
        endcase
        if (taken)
          nextPc = nextPc + simm;
      end
      HLT:
      begin
        refHaltPc = pcRef;
        done = 1'b1;
      end
      default: ;
    endcase
    pcRef = nextPc;
  end
  if (!done)
  begin
    $display("ERROR: reference model never reached a halt instruction");
    errorCount++;
  end
endfunction

`endif

// ==== tests/cpuTb.sv ====
`timescale 1ns/1ns
`include "cpu_params.svh"

module cpuTb
  import isaPkg::*, ctrlPkg::*;
();

  logic clk;
  logic reset;
  logic [`DATA_WIDTH-1:0] instrAddr, instr, pc;
  logic cyc, stb, we, ack, hlt;
  logic [`ADDR_WIDTH-1:0] adr;
  logic [`DATA_WIDTH-1:0] datOut, datIn;

  // Wishbone slave memory and what it saw
  logic [15:0] dataMem [65536];
  logic [15:0] obsAddr [$];
  logic [15:0] obsData [$];
  logic busy;
  int waitLeft;
  int busCount;

  int errorCount, passCount, failCount;
  int budget, cycleCount;
  int seedInit;
  string testName;

  `include "refModel.svh"

  cpu i_dut (
    .clk(clk), .reset(reset), .instrAddr(instrAddr), .instr(instr),
    .cyc(cyc), .stb(stb), .we(we), .adr(adr), .datOut(datOut), .datIn(datIn), .ack(ack),
    .hlt(hlt), .pc(pc)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //****************************************
  // Instruction ROM and Wishbone slave
  //****************************************
  always @(negedge clk)
  begin
    instr <= prog[instrAddr[7:0]];
    ack <= 1'b0;
    if (reset)
      busy = 1'b0;
    else if (cyc && stb)
    begin
      // New request draws 0 to 3 wait cycles
      if (!busy)
      begin
        busy = 1'b1;
        waitLeft = $urandom_range(3, 0);
      end
      if (waitLeft == 0)
      begin
        busy = 1'b0;
        ack <= 1'b1;
        busCount++;
        if (we)
        begin
          dataMem[adr] = datOut;
          obsAddr.push_back(adr);
          obsData.push_back(datOut);
        end
        else
          datIn <= dataMem[adr];
      end
      else
        waitLeft--;
    end
  end

  // Store checker against the model's list
  initial
  begin
    logic [15:0] a, d, ea, ed;
    int storeNum;
    storeNum = 0;
    forever
    begin
      @(posedge clk);
      while (obsAddr.size() > 0)
      begin
        a = obsAddr.pop_front();
        d = obsData.pop_front();
        storeNum++;
        assert (expAddr.size() > 0)
        else
        begin
          $display("ERROR at %0t: extra store of %h to %h in %s", $time, d, a, testName);
          errorCount++;
        end
        if (expAddr.size() > 0)
        begin
          ea = expAddr.pop_front();
          ed = expData.pop_front();
          assert (a == ea && d == ed)
          else
          begin
            $display("MISMATCH at %0t: store %0d wrote %h to %h, expected %h to %h",
                     $time, storeNum, d, a, ed, ea);
            errorCount++;
          end
        end
      end
    end
  end

  // Watchdog sized per test
  initial
  begin
    while (!(budget > 0 && cycleCount > budget))
    begin
      @(posedge clk);
      if (budget > 0)
        cycleCount++;
    end
    $display("ERROR: the run timed out in %s after %0d cycles", testName, cycleCount);
    $display("TESTS FAILED");
    $finish;
  end

  //****************************************
  // Test programs
  //****************************************
  function automatic void aluProgram();
    clearProgram();
    emitImm(LLI, 0, 8'h40);
    emitImm(LLI, 1, 8'($urandom));
    emitImm(LLI, 2, 8'($urandom));
    emitImm(LLI, 3, 8'($urandom));
    // Widen r1 to a full 16-bit operand
    emitReg(SLL, 3, 3, 8);
    emitReg(XOR, 1, 1, 3);
    for (int k = 0; k < 7; k++)
      emitReg(opcodeT'(k[3:0]), 4 + k, 1, (k >= 5) ? $urandom_range(15, 0) : 2);
    for (int k = 0; k < 7; k++)
      emitReg(SW, 4 + k, 0, k);
    emitReg(SW, 1, 0, 7);
    emitReg(SW, 2, 0, 8);
    emitImm(HLT, 0, 8'h00);
  endfunction

  function automatic void chainProgram();
    opcodeT op;
    int rt;
    clearProgram();
    emitImm(LLI, 15, 8'h60);
    emitImm(LLI, 1, 8'($urandom));
    emitImm(LLI, 2, 8'($urandom));
    // Each step reads the step before, each store reads the fresh result
    for (int k = 3; k < 15; k++)
    begin
      op = opcodeT'($urandom_range(6, 0));
      rt = (op == SLL || op == SRL) ? $urandom_range(15, 0) : $urandom_range(k - 1, 1);
      emitReg(op, k, k - 1, rt);
      emitReg(SW, k, 15, k - 3);
    end
    emitImm(HLT, 0, 8'h00);
  endfunction

  function automatic void memoryProgram();
    clearProgram();
    emitImm(LLI, 0, 8'h20);
    emitImm(LLI, 3, 8'($urandom));
    for (int k = 0; k < 6; k++)
    begin
      emitImm(LLI, 1, 8'($urandom));
      emitReg(SW, 1, 0, k);
    end
    for (int k = 0; k < 6; k++)
    begin
      emitReg(LW, 2, 0, k);
      emitReg(XOR, 2, 2, 3);
      emitReg(SW, 2, 0, k + 8);
    end
    // Back-to-back loads, then an untouched word
    emitReg(LW, 5, 0, 0);
    emitReg(LW, 6, 0, 1);
    emitReg(ADD, 7, 5, 6);
    emitReg(SW, 7, 0, 6);
    emitReg(LW, 4, 0, 15);
    emitReg(SW, 4, 0, 14);
    emitImm(HLT, 0, 8'h00);
  endfunction

  function automatic void branchProgram();
    clearProgram();
    emitImm(LLI, 12, 8'h70);
    emitImm(LLI, 13, 8'h04);
    emitImm(LLI, 5, 8'h55);
    emitImm(LLI, 9, 8'h7F);
    emitReg(SLL, 9, 9, 8);
    emitImm(LLI, 10, 8'h05);
    emitImm(LLI, 11, 8'h03);
    for (int c = 0; c <= 5; c++)
      for (int f = 0; f < 3; f++)
      begin
        emitReg(ADD, 12, 12, 13);
        // Zero, negative with overflow, or plain positive
        case (f)
          0: emitReg(SUB, 3, 10, 10);
          1: emitReg(ADD, 3, 9, 9);
          default: emitReg(SUB, 3, 10, 11);
        endcase
        emitImm(BR, c, 8'h03);
        emitReg(SW, 5, 12, 0);
        emitReg(SW, 5, 12, 1);
        emitReg(SW, 5, 12, 2);
        emitReg(SW, 12, 12, 3);
      end
    // Countdown loop with a backward branch
    emitImm(LLI, 7, 8'h04);
    emitImm(LLI, 8, 8'h01);
    emitReg(SW, 7, 12, 4);
    emitReg(SUB, 7, 7, 8);
    emitImm(BR, NE, 8'hFD);
    emitImm(HLT, 0, 8'h00);
  endfunction

  function automatic void haltProgram();
    clearProgram();
    emitImm(LLI, 0, 8'h30);
    emitImm(LLI, 1, 8'($urandom));
    emitReg(SW, 1, 0, 0);
    emitImm(BR, AL, 8'h01);
    emitImm(HLT, 0, 8'h00);
    emitReg(LW, 2, 0, 0);
    emitReg(SW, 2, 0, 1);
    emitImm(HLT, 0, 8'h00);
    emitReg(SW, 1, 0, 2);
    emitReg(SW, 1, 0, 3);
  endfunction

  //****************************************
  // Test sequencing
  //****************************************
  task automatic runProgram(input string name);
    int errorsAtStart;
    logic [15:0] pcAtHalt;
    errorsAtStart = errorCount;
    runReference();
    @(negedge clk);
    reset <= 1'b1;
    @(negedge clk);
    for (int a = 0; a < 65536; a++)
      dataMem[a] = fillWord(16'(a));
    obsAddr.delete();
    obsData.delete();
    busCount = 0;
    repeat (4) @(negedge clk);
    testName = name;
    cycleCount = 0;
    budget = 40 * refInstrCount + 8 * refMemOps;
    reset <= 1'b0;
    while (hlt !== 1'b1)
      @(negedge clk);
    assert (pc == refHaltPc + 16'd1)
    else
    begin
      $display("MISMATCH at %0t: halted with pc %h, expected %h", $time, pc, refHaltPc + 16'd1);
      errorCount++;
    end
    pcAtHalt = pc;
    repeat (20)
    begin
      @(negedge clk);
      assert (hlt && pc == pcAtHalt)
      else
      begin
        $display("ERROR at %0t: pc moved or hlt dropped after the halt", $time);
        errorCount++;
      end
      assert (!cyc)
      else
      begin
        $display("ERROR at %0t: a bus cycle started after the halt", $time);
        errorCount++;
      end
    end
    assert (expAddr.size() == 0)
    else
    begin
      $display("ERROR: %0d expected stores never reached the bus", expAddr.size());
      errorCount++;
    end
    assert (busCount == refMemOps)
    else
    begin
      $display("MISMATCH at %0t: %0d bus cycles, expected %0d", $time, busCount, refMemOps);
      errorCount++;
    end
    budget = 0;
    if (errorCount == errorsAtStart)
    begin
      passCount++;
      $display("PASS: %s", name);
    end
    else
    begin
      failCount++;
      $display("FAIL: %s", name);
    end
  endtask

  initial
  begin
    seedInit = $urandom(27);
    reset = 1'b1;
    instr = '0;
    datIn = '0;
    ack = 1'b0;
    busy = 1'b0;
    waitLeft = 0;
    busCount = 0;
    errorCount = 0;
    passCount = 0;
    failCount = 0;
    budget = 0;
    cycleCount = 0;
    testName = "reset";
    clearProgram();
    aluProgram();
    runProgram("ALU operations");
    chainProgram();
    runProgram("dependency chains");
    memoryProgram();
    runProgram("loads and stores with wait states");
    branchProgram();
    runProgram("branch conditions");
    haltProgram();
    runProgram("halt");
    $display("Tests: %0d passed, %0d failed, %0d errors", passCount, failCount, errorCount);
    if (errorCount == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule
